// File: build.f
+incdir+testbench
verilog/scan_pkg.sv
verilog/keyword_dfa.sv
verilog/stream_state_mem.sv
verilog/match_tally.sv
verilog/scan_control.sv
verilog/stream_scan_top.sv
testbench/tb_stream_scan.sv

// File: testbench/scan_model.svh
`ifndef SCAN_MODEL_SVH
`define SCAN_MODEL_SVH

// Reference model of the keyword rules, included inside the testbench module
// Relies on NUM_RULES of the enclosing module

// Saved automaton state per rule and stream
logic [scan_pkg::STATE_W-1:0] saved_state [NUM_RULES][scan_pkg::NUM_STREAMS];
// State and fired flag of the open packet
logic [scan_pkg::STATE_W-1:0] live_state [NUM_RULES];
logic                         live_fired [NUM_RULES];
// Expected packet counters
logic [scan_pkg::CNT_W-1:0]   model_count [NUM_RULES];
// Stream of the open packet
int                           open_stream;

// Character at position pos of the keyword for a rule
function automatic logic [scan_pkg::CHAR_W-1:0] key_char(input int rule, input int pos);
   logic [scan_pkg::KEY_W-1:0] word;
   word = scan_pkg::KEYWORDS[rule];
   return word[scan_pkg::KEY_W-1 - scan_pkg::CHAR_W*pos -: scan_pkg::CHAR_W];
endfunction

// Everything back to the post-reset picture
task automatic clear_model();
   for (int r = 0; r < NUM_RULES; r++)
   begin
      live_state[r]  = '0;
      live_fired[r]  = 1'b0;
      model_count[r] = '0;
   end
endtask

// Packet start restores or zeroes the state and lowers the flags
task automatic open_stream_state(input int stream, input bit is_new);
   open_stream = stream;
   for (int r = 0; r < NUM_RULES; r++)
   begin
      live_state[r] = is_new ? '0 : saved_state[r][stream];
      live_fired[r] = 1'b0;
   end
endtask

// One byte through every rule
task automatic advance_on_byte(input logic [scan_pkg::CHAR_W-1:0] c);
   int len;
   for (int r = 0; r < NUM_RULES; r++)
   begin
      len = scan_pkg::KEY_LENS[r];
      if (c == key_char(r, live_state[r]))
      begin
         // Expected character may complete the keyword
         if (live_state[r] + 1 == len)
         begin
            live_state[r] = '0;
            live_fired[r] = 1'b1;
         end
         else
         begin
            live_state[r] = live_state[r] + 1'b1;
         end
      end
      else if (c == key_char(r, 0))
      begin
         live_state[r] = 1;
      end
      else
      begin
         live_state[r] = '0;
      end
   end
endtask

// End of packet with the enable mask
task automatic close_packet_state(input logic [NUM_RULES-1:0] mask);
   for (int r = 0; r < NUM_RULES; r++)
   begin
      if (mask[r])
      begin
         model_count[r] = model_count[r] + live_fired[r];
         saved_state[r][open_stream] = live_state[r];
      end
      else
      begin
         // Disabled rule drops its flag and neither counts nor saves
         live_fired[r] = 1'b0;
      end
   end
endtask

`endif

// File: testbench/tb_stream_scan.sv
`timescale 1ns/1ps

module tb_stream_scan;

   localparam int NUM_RULES      = 2;
   // Directed packets of tests 2 to 4, then the random run
   localparam int DIRECT_PACKETS = 11;
   localparam int RANDOM_PACKETS = 300;
   localparam int CYCLE_LIMIT    = 40 * (DIRECT_PACKETS + RANDOM_PACKETS) + 200;

   logic                                clk;
   logic                                rst_n;
   logic                                load_state;
   logic [scan_pkg::STREAM_W-1:0]        stream_id;
   logic                                new_stream_id;
   logic [scan_pkg::CHAR_W-1:0]          char_in;
   logic                                char_in_vld;
   logic                                eop;
   logic [NUM_RULES-1:0]                enable;
   logic [NUM_RULES*scan_pkg::CNT_W-1:0] count;
   logic [NUM_RULES-1:0]                fired;

   int     error_count;
   int     test_errors_start;
   int     tests_run;
   int     tests_bad;
   int     cycle_count;
   integer seed;

   // Bytes of the next packet
   logic [scan_pkg::CHAR_W-1:0] pkt_bytes[$];
   // Streams whose saved state is valid in every rule
   bit stream_used [scan_pkg::NUM_STREAMS];

   `include "scan_model.svh"

   stream_scan_top #(
      .NUM_RULES (NUM_RULES)
   ) dut (
      .clk           (clk),
      .rst_n         (rst_n),
      .load_state    (load_state),
      .stream_id     (stream_id),
      .new_stream_id (new_stream_id),
      .char_in       (char_in),
      .char_in_vld   (char_in_vld),
      .eop           (eop),
      .enable        (enable),
      .count         (count),
      .fired         (fired)
   );

   // 100 ns clock
   initial
   begin
      clk = 1'b0;
   end

   always #50 clk = ~clk;

   // Run limit
   always @(posedge clk)
   begin
      cycle_count <= cycle_count + 1;
      if (cycle_count >= CYCLE_LIMIT)
      begin
         $display("timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
         $display("sim failed");
         $finish;
      end
   end

   task automatic compare_value(input string name, input logic [31:0] expected,
                                input logic [31:0] actual);
      assert (expected === actual)
      else
      begin
         $display("mismatch at %0t ns: %s expected %0h actual %0h",
                  $time, name, expected, actual);
         error_count++;
      end
   endtask

   // Fired flags always, counters when asked
   task automatic compare_outputs(input bit with_count);
      for (int r = 0; r < NUM_RULES; r++)
      begin
         compare_value($sformatf("fired[%0d]", r), live_fired[r], fired[r]);
         if (with_count)
         begin
            compare_value($sformatf("count[%0d]", r), model_count[r],
                          count[r*scan_pkg::CNT_W +: scan_pkg::CNT_W]);
         end
      end
   endtask

   task automatic push_text(input string s);
      for (int i = 0; i < s.len(); i++)
      begin
         pkt_bytes.push_back(s[i]);
      end
   endtask

   // Full packet with the gaps the control expects
   // Entered and left at a falling edge
   task automatic send_packet(input int stream, input bit is_new,
                              input logic [NUM_RULES-1:0] mask);
      @(negedge clk);
      load_state    = 1'b1;
      stream_id     = stream[scan_pkg::STREAM_W-1:0];
      new_stream_id = is_new;
      open_stream_state(stream, is_new);
      @(negedge clk);
      load_state = 1'b0;
      // Second idle cycle, restore has landed after this
      @(negedge clk);
      for (int i = 0; i < pkt_bytes.size(); i++)
      begin
         @(negedge clk);
         char_in     = pkt_bytes[i];
         char_in_vld = 1'b1;
         advance_on_byte(pkt_bytes[i]);
      end
      @(negedge clk);
      char_in_vld = 1'b0;
      repeat (2) @(negedge clk);
      // Flags settled after the last byte
      compare_outputs(1'b0);
      eop    = 1'b1;
      enable = mask;
      close_packet_state(mask);
      @(negedge clk);
      eop = 1'b0;
      compare_outputs(1'b1);
      pkt_bytes.delete();
   endtask

   task automatic start_test();
      test_errors_start = error_count;
   endtask

   task automatic report_test(input int num, input string name);
      tests_run++;
      if (error_count == test_errors_start)
      begin
         $display("test %0d %s: ok", num, name);
      end
      else
      begin
         tests_bad++;
         $display("test %0d %s: %0d errors", num, name, error_count - test_errors_start);
      end
   endtask

   // Random packets over all streams with the keyword letters favoured
   task automatic run_random(input int packets);
      string  letters;
      integer r;
      int     stream;
      int     len;
      bit     is_new;
      logic [NUM_RULES-1:0] mask;
      letters = "USERPASX";
      for (int p = 0; p < packets; p++)
      begin
         r      = $random(seed);
         stream = r[5:0];
         // Zero restore until every rule has saved a state for the stream
         is_new = !stream_used[stream] || (r[9:7] == 3'd0);
         // Each rule enabled three times out of four
         mask = r[NUM_RULES+11:12] | r[NUM_RULES+19:20];
         // A packet with all rules enabled leaves a valid entry in each
         if (&mask)
         begin
            stream_used[stream] = 1'b1;
         end
         len  = r[31:24] % 12 + 1;
         for (int i = 0; i < len; i++)
         begin
            r = $random(seed);
            if (r[1:0] != 2'd0)
            begin
               pkt_bytes.push_back(letters[r[10:8]]);
            end
            else
            begin
               pkt_bytes.push_back(r[23:16]);
            end
         end
         send_packet(stream, is_new, mask);
      end
   endtask

   initial
   begin
      seed          = 29;
      error_count   = 0;
      tests_run     = 0;
      tests_bad     = 0;
      cycle_count   = 0;
      rst_n         = 1'b0;
      load_state    = 1'b0;
      stream_id     = '0;
      new_stream_id = 1'b0;
      char_in       = '0;
      char_in_vld   = 1'b0;
      eop           = 1'b0;
      enable        = '0;
      clear_model();

      // Reset for 5 cycles, released on a falling edge
      repeat (5) @(posedge clk);
      @(negedge clk);
      rst_n = 1'b1;

      start_test();
      compare_outputs(1'b1);
      report_test(1, "reset values");

      // Both keywords, each on a new stream
      start_test();
      push_text("aUSERb");
      send_packet(1, 1'b1, 2'b11);
      push_text("PASS");
      send_packet(2, 1'b1, 2'b11);
      push_text("UPASSER");
      send_packet(3, 1'b1, 2'b11);
      report_test(2, "single packets");

      // USER split over two packets of stream 5 with stream 9 in between
      start_test();
      push_text("xUS");
      send_packet(5, 1'b1, 2'b11);
      push_text("PASSy");
      send_packet(9, 1'b1, 2'b11);
      push_text("ERz");
      send_packet(5, 1'b0, 2'b11);
      // Same split, but the second packet restarts the stream
      push_text("US");
      send_packet(7, 1'b1, 2'b11);
      push_text("ER");
      send_packet(7, 1'b1, 2'b11);
      report_test(3, "split keyword");

      // Rule 0 off at eop keeps the saved prefix of stream 12
      start_test();
      push_text("US");
      send_packet(12, 1'b1, 2'b11);
      push_text("ER");
      send_packet(12, 1'b0, 2'b10);
      push_text("ER");
      send_packet(12, 1'b0, 2'b11);
      report_test(4, "disabled rule");

      // Streams from the directed tests count as used
      stream_used[1]  = 1'b1;
      stream_used[2]  = 1'b1;
      stream_used[3]  = 1'b1;
      stream_used[5]  = 1'b1;
      stream_used[7]  = 1'b1;
      stream_used[9]  = 1'b1;
      stream_used[12] = 1'b1;
      start_test();
      run_random(RANDOM_PACKETS);
      report_test(5, "random packets");

      $display("summary: %0d tests, %0d with errors, %0d check errors",
               tests_run, tests_bad, error_count);
      if (error_count == 0)
      begin
         $display("sim passed");
      end
      else
      begin
         $display("sim failed");
      end
      $finish;
   end

endmodule

// File: verilog/stream_scan_top.sv
`timescale 1ns/1ps

module stream_scan_top #(
   parameter int NUM_RULES = 2
) (
   input  logic                                clk,
   input  logic                                rst_n,
   input  logic                                load_state,
   input  logic [scan_pkg::STREAM_W-1:0]        stream_id,
   input  logic                                new_stream_id,
   input  logic [scan_pkg::CHAR_W-1:0]          char_in,
   input  logic                                char_in_vld,
   input  logic                                eop,
   input  logic [NUM_RULES-1:0]                enable,
   output logic [NUM_RULES*scan_pkg::CNT_W-1:0] count,
   output logic [NUM_RULES-1:0]                fired
);

   // Shared packet control
   logic [scan_pkg::STREAM_W-1:0] cur_stream;
   logic                          restore;
   logic                          restore_new;
   logic                          commit;
   logic                          clear;

   scan_control u_scan_control (
      .clk           (clk),
      .rst_n         (rst_n),
      .load_state    (load_state),
      .stream_id     (stream_id),
      .new_stream_id (new_stream_id),
      .eop           (eop),
      .cur_stream    (cur_stream),
      .restore       (restore),
      .restore_new   (restore_new),
      .commit        (commit),
      .clear         (clear)
   );

   // One datapath per keyword rule
   for (genvar r = 0; r < NUM_RULES; r++)
   begin : g_rule
      logic [scan_pkg::STATE_W-1:0] state_out;
      logic [scan_pkg::STATE_W-1:0] restore_state;
      logic                         restore_vld;
      logic                         accept;

      // Saved per-stream state of this rule
      stream_state_mem u_state_mem (
         .clk           (clk),
         .cur_stream    (cur_stream),
         .restore       (restore),
         .restore_new   (restore_new),
         .commit        (commit),
         .rule_en       (enable[r]),
         .state_in      (state_out),
         .restore_state (restore_state),
         .restore_vld   (restore_vld)
      );

      // Keyword matcher, table entry equals rule index
      keyword_dfa #(
         .RULE_IDX (r)
      ) u_dfa (
         .clk           (clk),
         .rst_n         (rst_n),
         .char_in       (char_in),
         .char_in_vld   (char_in_vld),
         .restore_state (restore_state),
         .restore_vld   (restore_vld),
         .state_out     (state_out),
         .accept        (accept)
      );

      // Fired flag and packet counter
      match_tally u_tally (
         .clk     (clk),
         .rst_n   (rst_n),
         .clear   (clear),
         .accept  (accept),
         .commit  (commit),
         .rule_en (enable[r]),
         .count   (count[r*scan_pkg::CNT_W +: scan_pkg::CNT_W]),
         .fired   (fired[r])
      );
   end

endmodule

// File: verilog/scan_control.sv
`timescale 1ns/1ps

module scan_control (
   input  logic                         clk,
   input  logic                         rst_n,
   input  logic                         load_state,
   input  logic [scan_pkg::STREAM_W-1:0] stream_id,
   input  logic                         new_stream_id,
   input  logic                         eop,
   output logic [scan_pkg::STREAM_W-1:0] cur_stream,
   output logic                         restore,
   output logic                         restore_new,
   output logic                         commit,
   output logic                         clear
);

   // load_state delayed by one cycle
   logic load_d;

   always_ff @(posedge clk)
   begin
      if (!rst_n)
      begin
         load_d      <= 1'b0;
         cur_stream  <= '0;
         restore_new <= 1'b0;
      end
      else
      begin
         load_d <= load_state;
         // Stream of the open packet, held until the next start
         if (load_state)
         begin
            cur_stream  <= stream_id;
            restore_new <= new_stream_id;
         end
      end
   end

   // Restore and flag clear share the cycle after packet start
   assign restore = load_d;
   assign clear   = load_d;

   // All rules close the packet on the same edge
   assign commit = eop;

endmodule

// File: verilog/match_tally.sv
`timescale 1ns/1ps

module match_tally (
   input  logic                      clk,
   input  logic                      rst_n,
   input  logic                      clear,
   input  logic                      accept,
   input  logic                      commit,
   input  logic                      rule_en,
   output logic [scan_pkg::CNT_W-1:0] count,
   output logic                      fired
);

   always_ff @(posedge clk)
   begin
      if (!rst_n)
      begin
         count <= '0;
         fired <= 1'b0;
      end
      else
      begin
         // Speculative flag starts each packet low
         if (clear)
         begin
            fired <= 1'b0;
         end

         // Any keyword hit in the packet sets it
         if (accept)
         begin
            fired <= 1'b1;
         end

         // Packet boundary
         if (commit)
         begin
            if (rule_en)
            begin
               // At most one count per packet; counter wraps
               count <= count + {{(scan_pkg::CNT_W-1){1'b0}}, fired};
            end
            else
            begin
               // Rule off for this packet, discard the hit
               fired <= 1'b0;
            end
         end
      end
   end

endmodule

// File: verilog/stream_state_mem.sv
`timescale 1ns/1ps

module stream_state_mem (
   input  logic                         clk,
   input  logic [scan_pkg::STREAM_W-1:0] cur_stream,
   input  logic                         restore,
   input  logic                         restore_new,
   input  logic                         commit,
   input  logic                         rule_en,
   input  logic [scan_pkg::STATE_W-1:0]  state_in,
   output logic [scan_pkg::STATE_W-1:0]  restore_state,
   output logic                         restore_vld
);

   // One saved automaton state per stream
   logic [scan_pkg::STATE_W-1:0] state_mem [scan_pkg::NUM_STREAMS];

   // Save the automaton state at end of packet
   // A disabled rule keeps the previous entry
   always_ff @(posedge clk)
   begin
      if (commit && rule_en)
      begin
         state_mem[cur_stream] <= state_in;
      end
   end

   // Registered read on restore
   // A new stream starts from zero, whatever the entry holds
   always_ff @(posedge clk)
   begin
      if (restore)
      begin
         if (restore_new)
         begin
            restore_state <= '0;
         end
         else
         begin
            restore_state <= state_mem[cur_stream];
         end
      end
   end

   // Load strobe to the automaton, in step with the read data
   always_ff @(posedge clk)
   begin
      restore_vld <= restore;
   end

endmodule

// File: verilog/keyword_dfa.sv
`timescale 1ns/1ps

module keyword_dfa #(
   parameter int RULE_IDX = 0
) (
   input  logic                       clk,
   input  logic                       rst_n,
   input  logic [scan_pkg::CHAR_W-1:0]  char_in,
   input  logic                       char_in_vld,
   input  logic [scan_pkg::STATE_W-1:0] restore_state,
   input  logic                       restore_vld,
   output logic [scan_pkg::STATE_W-1:0] state_out,
   output logic                       accept
);

   // Keyword of this rule, taken from the shared table
   localparam logic [scan_pkg::KEY_W-1:0] KEY_WORD = scan_pkg::KEYWORDS[RULE_IDX];
   localparam logic [scan_pkg::STATE_W-1:0] KEY_LEN = scan_pkg::KEY_LENS[RULE_IDX];

   // First keyword character, used to restart after a mismatch
   localparam logic [scan_pkg::CHAR_W-1:0] FIRST_CHAR =
      KEY_WORD[scan_pkg::KEY_W-1 -: scan_pkg::CHAR_W];

   // Number of keyword characters matched so far
   logic [scan_pkg::STATE_W-1:0] state;

   logic [scan_pkg::CHAR_W-1:0] expect_char;
   logic                        hit;
   logic                        last;

   // Next character the keyword expects at the current state
   assign expect_char =
      KEY_WORD[scan_pkg::KEY_W-1 - scan_pkg::CHAR_W*int'(state) -: scan_pkg::CHAR_W];

   assign hit  = (char_in == expect_char);
   // One character left before the keyword completes
   assign last = (state == KEY_LEN - 1'b1);

   always_ff @(posedge clk)
   begin
      if (!rst_n)
      begin
         state  <= '0;
         accept <= 1'b0;
      end
      else
      begin
         // Accept is a single-cycle pulse
         accept <= 1'b0;
         // Saved state of the stream overrides any byte
         if (restore_vld)
         begin
            state <= restore_state;
         end
         else if (char_in_vld)
         begin
            if (hit && last)
            begin
               // Keyword complete, start over
               state  <= '0;
               accept <= 1'b1;
            end
            else if (hit)
            begin
               state <= state + 1'b1;
            end
            else if (char_in == FIRST_CHAR)
            begin
               // Mismatch that may begin a new keyword
               state <= 1;
            end
            else
            begin
               state <= '0;
            end
         end
      end
   end

   assign state_out = state;

endmodule

// File: verilog/scan_pkg.sv
package scan_pkg;

   // Stream id width and number of interleaved streams
   localparam int STREAM_W    = 6;
   localparam int NUM_STREAMS = 64;

   // Input byte width
   localparam int CHAR_W = 8;

   // Per-rule packet counter width
   localparam int CNT_W = 16;

   // Longest keyword and the state width that counts up to it
   localparam int MAX_KEY_LEN = 8;
   localparam int STATE_W     = 4;

   // Size of the keyword table
   localparam int NUM_KEYS = 4;
   localparam int KEY_W    = MAX_KEY_LEN * CHAR_W;

   // Keyword table, first character in the top byte of each entry
   // Entries must not overlap themselves
   localparam logic [NUM_KEYS-1:0][KEY_W-1:0] KEYWORDS = {
      {"STOR", 32'h0},
      {"LIST", 32'h0},
      {"PASS", 32'h0},
      {"USER", 32'h0}
   };

   // Keyword length in characters, same order as the table
   localparam logic [NUM_KEYS-1:0][STATE_W-1:0] KEY_LENS = {
      4'd4,
      4'd4,
      4'd4,
      4'd4
   };

endpackage
